//--- tb.f
verilog/debugPkg.sv
verilog/hostBusSync.sv
verilog/debugRequestFsm.sv
verilog/debugAddrCounter.sv
verilog/debugRegisters.sv
verilog/debugPort.sv
verif/clockGen.sv
verif/debugPortTb.sv

//--- Makefile
TOP = debugPortTb

.PHONY: compile run clean

compile:
	verilator --binary --timing -f tb.f --top-module $(TOP)

# Fails unless the simulation output holds the pass line
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- verif/debugPortTb.sv
module debugPortTb import debugPkg::*; ();

	// **********************************************************
	// DUT signals
	// **********************************************************
	logic        clk;
	logic        arstN;
	byte_t       din;
	regAddr_e    addr;
	logic        rdN;
	logic        wrN;
	byte_t       dout;
	logic        addrIncEn;
	logic        ldDataEn;
	dataSel_e    dataSel;
	captureSrc_t sources;
	logic        debugAck;
	debugCtrl_t  ctrl;
	logic        cpuReset;
	word_t       debugAddr;
	word_t       debugData;
	logic        debugReq;

	integer seed = 32'h5e78_649b;	// Ack delay generator
	int     errors = 0;
	int     checks = 0;

	typedef enum logic [2:0] {
		hostWrite, hostRead, cpuLoad, cpuInc, expectReq, expectNoReq
	} action_e;

	// One table row with sel holding a register address or capture source
	typedef struct packed {
		action_e act;
		logic [2:0] sel;
		byte_t   data;
		word_t   expected;
	} step_t;

	localparam int numSteps = 33;

	// **********************************************************
	// Stimulus table
	// **********************************************************
	step_t steps [numSteps] = '{
		'{hostWrite,   regMode,          8'h04, 16'h0040},	// Host reset request
		'{hostWrite,   regMode,          8'h00, 16'h0000},
		'{hostWrite,   regMode,          8'h03, 16'h0030},	// Debug and stop
		'{hostWrite,   regOp,            8'h06, 16'h0036},
		'{hostRead,    regMode,          8'h00, 16'h0003},
		'{hostRead,    regOp,            8'h00, 16'h0006},
		'{hostWrite,   regDataL,         8'h34, 16'h0034},
		'{hostWrite,   regDataH,         8'h12, 16'h1234},	// Auto-inc off
		'{hostWrite,   regAddrL,         8'hA7, 16'h00A6},	// Bit 0 dropped
		'{hostWrite,   regAddrH,         8'h5C, 16'h5CA6},
		'{hostRead,    regAddrL,         8'h00, 16'h00A6},
		'{hostRead,    regAddrH,         8'h00, 16'h005C},
		'{hostRead,    regSpare,         8'h00, 16'h0000},
		'{cpuLoad,     {1'b0, selDin},    8'h00, 16'hA1B2},
		'{cpuLoad,     {1'b0, selRegB},   8'h00, 16'hC3D4},
		'{cpuLoad,     {1'b0, selCc},     8'h00, 16'h0E5F},
		'{cpuLoad,     {1'b0, selPcNext}, 8'h00, 16'h7788},
		'{hostWrite,   regAddrL,         8'hFE, 16'h5CFE},
		'{hostWrite,   regAddrH,         8'h00, 16'h00FE},
		'{cpuInc,      3'd0,             8'h00, 16'h0100},	// Carry into high byte
		'{cpuInc,      3'd0,             8'h00, 16'h0102},
		'{hostRead,    regAddrL,         8'h00, 16'h0002},
		'{hostRead,    regAddrH,         8'h00, 16'h0001},
		'{hostWrite,   regMode,          8'h08, 16'h0006},	// Mode request
		'{expectReq,   3'd0,             8'h00, 16'h0000},
		'{hostRead,    regStatus,        8'h00, 16'h0000},
		'{hostWrite,   regOp,            8'h01, 16'h0001},
		'{hostWrite,   regDataH,         8'h9A, 16'h9A34},	// Auto-inc request
		'{expectReq,   3'd0,             8'h00, 16'h0000},
		'{hostWrite,   regOp,            8'h00, 16'h0000},
		'{hostWrite,   regDataH,         8'h55, 16'h5534},
		'{expectNoReq, 3'd0,             8'h00, 16'h0000},
		'{hostRead,    regStatus,        8'h00, 16'h0000}
	};

	clockGen uClk (.clk(clk));

	debugPort dut (
		.clk(clk), .arstN(arstN), .din(din), .addr(addr), .rdN(rdN), .wrN(wrN),
		.dout(dout), .addrIncEn(addrIncEn), .ldDataEn(ldDataEn), .dataSel(dataSel),
		.sources(sources), .debugAck(debugAck), .ctrl(ctrl), .cpuReset(cpuReset),
		.debugAddr(debugAddr), .debugData(debugData), .debugReq(debugReq)
	);

	// **********************************************************
	// Helpers
	// **********************************************************
	task automatic stepCycle(input int n);
		repeat (n) begin
			@(posedge clk);
			#10;	// Drive point after the edge
		end
	endtask

	task automatic checkValue(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	// Strobe held 3 cycles then a settle past the sync latency
	task automatic writeHostReg(input regAddr_e a, input byte_t d);
		addr = a;
		din  = d;
		wrN  = 1'b0;
		stepCycle(3);
		wrN  = 1'b1;
		stepCycle(6);
	endtask

	task automatic readHostReg(input regAddr_e a, output byte_t value);
		addr = a;
		rdN  = 1'b0;
		stepCycle(1);
		value = dout;
		rdN  = 1'b1;
	endtask

	task automatic waitReqLevel(input logic level);
		int n;
		n = 0;
		while (debugReq !== level && n < 200) begin
			stepCycle(1);
			n++;
		end
		if (debugReq !== level) begin
			errors++;
			$display("Timeout after 200 cycles waiting for debugReq to go %b", level);
		end
	endtask

	// CPU side of one four-phase handshake
	task automatic serveRequest();
		int    delay;
		byte_t st;
		waitReqLevel(1'b1);
		readHostReg(regStatus, st);
		checkValue("status busy", 16'h0001, {8'b0, st});
		delay = 1 + ($unsigned($random(seed)) % 4);
		stepCycle(delay);
		checkValue("debugReq before ack", 16'h0001, {15'b0, debugReq});	// Held until acked
		debugAck = 1'b1;
		waitReqLevel(1'b0);
		debugAck = 1'b0;
		stepCycle(3);
		checkValue("debugReq after handshake", 16'h0000, {15'b0, debugReq});	// Only one
	endtask

	// **********************************************************
	// Main sequence
	// **********************************************************
	initial begin
		step_t s;
		byte_t rd;
		byte_t hi;
		arstN     = 1'b0;
		din       = '0;
		addr      = regMode;
		rdN       = 1'b1;
		wrN       = 1'b1;
		addrIncEn = 1'b0;
		ldDataEn  = 1'b0;
		dataSel   = selDin;
		debugAck  = 1'b0;
		sources   = '{dinData: 16'hA1B2, regBData: 16'hC3D4, ccData: 16'h0E5F, pcNext: 16'h7788};

		stepCycle(8);
		checkValue("ctrl", 16'h0000, {9'b0, ctrl});
		checkValue("debugReq", 16'h0000, {15'b0, debugReq});
		checkValue("debugAddr", 16'h0000, debugAddr);
		checkValue("debugData", 16'h0000, debugData);
		checkValue("cpuReset", 16'h0001, {15'b0, cpuReset});	// Held during reset
		stepCycle(8);
		arstN = 1'b1;
		stepCycle(1);
		checkValue("cpuReset", 16'h0000, {15'b0, cpuReset});

		for (int i = 0; i < numSteps; i++) begin
			s = steps[i];
			case (s.act)
				hostWrite: begin
					writeHostReg(regAddr_e'(s.sel), s.data);
					case (regAddr_e'(s.sel))
						regMode: begin
							checkValue("ctrl", s.expected, {9'b0, ctrl});
							checkValue("cpuReset", {15'b0, s.data[2]}, {15'b0, cpuReset});
						end
						regOp:              checkValue("ctrl", s.expected, {9'b0, ctrl});
						regDataL, regDataH: checkValue("debugData", s.expected, debugData);
						default:            checkValue("debugAddr", s.expected, debugAddr);
					endcase
				end
				hostRead: begin
					readHostReg(regAddr_e'(s.sel), rd);
					checkValue("dout", s.expected, {8'b0, rd});
				end
				cpuLoad: begin
					dataSel  = dataSel_e'(s.sel[1:0]);
					ldDataEn = 1'b1;
					stepCycle(1);
					ldDataEn = 1'b0;
					readHostReg(regDataL, rd);
					readHostReg(regDataH, hi);
					checkValue("capture", s.expected, {hi, rd});
				end
				cpuInc: begin
					addrIncEn = 1'b1;
					stepCycle(1);
					addrIncEn = 1'b0;
					checkValue("debugAddr", s.expected, debugAddr);
				end
				expectReq: serveRequest();
				expectNoReq: begin
					// Watch 20 cycles for a stray request
					for (int n = 0; n < 20; n++) begin
						checkValue("debugReq", 16'h0000, {15'b0, debugReq});
						stepCycle(1);
					end
				end
				default: ;
			endcase
		end

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- verif/clockGen.sv
module clockGen (
	output logic clk
);

	// Period 100, first rising edge at 50
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

endmodule

//--- verilog/debugPort.sv
module debugPort import debugPkg::*; (
	input  logic        clk,
	input  logic        arstN,

	// Host bus
	input  byte_t       din,
	input  regAddr_e    addr,
	input  logic        rdN,
	input  logic        wrN,
	output byte_t       dout,

	// CPU side
	input  logic        addrIncEn,
	input  logic        ldDataEn,
	input  dataSel_e    dataSel,
	input  captureSrc_t sources,
	input  logic        debugAck,
	output debugCtrl_t  ctrl,
	output logic        cpuReset,
	output word_t       debugAddr,
	output word_t       debugData,
	output logic        debugReq
);

	logic       wrValid;	// Synchronized write event
	hostWrite_t hostWr;
	logic       busy;
	logic       autoInc;

	assign autoInc = ctrl.op[0];

	// CPU held in reset by the port or by the host
	assign cpuReset = ~arstN | ctrl.cpuResetReq;

	// **********************************************************
	// Instances
	// **********************************************************
	hostBusSync uSync (
		.clk(clk), .arstN(arstN), .wrN(wrN), .addr(addr), .din(din),
		.wrValid(wrValid), .hostWr(hostWr)
	);

	debugRequestFsm uReq (
		.clk(clk), .arstN(arstN), .wrValid(wrValid), .hostWr(hostWr),
		.autoInc(autoInc), .debugAck(debugAck), .debugReq(debugReq), .busy(busy)
	);

	debugAddrCounter uAddr (
		.clk(clk), .arstN(arstN), .wrValid(wrValid), .hostWr(hostWr),
		.addrIncEn(addrIncEn), .debugAddr(debugAddr)
	);

	debugRegisters uRegs (
		.clk(clk), .arstN(arstN), .wrValid(wrValid), .hostWr(hostWr),
		.ldDataEn(ldDataEn), .dataSel(dataSel), .sources(sources),
		.rdN(rdN), .addr(addr), .debugAddr(debugAddr), .busy(busy),
		.ctrl(ctrl), .debugData(debugData), .dout(dout)
	);

endmodule

//--- verilog/debugRegisters.sv
module debugRegisters import debugPkg::*; (
	input  logic        clk,
	input  logic        arstN,
	input  logic        wrValid,
	input  hostWrite_t  hostWr,
	input  logic        ldDataEn,	// CPU capture strobe
	input  dataSel_e    dataSel,
	input  captureSrc_t sources,
	input  logic        rdN,	// Host read strobe
	input  regAddr_e    addr,	// Host read address, unsynchronized
	input  word_t       debugAddr,
	input  logic        busy,
	output debugCtrl_t  ctrl,
	output word_t       debugData,	// Write data to CPU
	output byte_t       dout
);

	word_t capture;		// Read-back word from the CPU
	word_t captureMux;

	// **********************************************************
	// Host writable registers
	// **********************************************************
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrl      <= '0;
			debugData <= '0;
		end else if (wrValid) begin
			case (hostWr.regSel)
				regMode: begin
					// Bit 2 reset, bit 1 debug, bit 0 stop
					ctrl.cpuResetReq <= hostWr.data[2];
					ctrl.debugMode   <= hostWr.data[1];
					ctrl.debugStop   <= hostWr.data[0];
				end
				regOp:    ctrl.op         <= hostWr.data[3:0];
				regDataL: debugData[7:0]  <= hostWr.data;
				regDataH: debugData[15:8] <= hostWr.data;
				default: ;	// Address regs live in the counter
			endcase
		end
	end

	// **********************************************************
	// Capture register
	// **********************************************************
	always_comb begin
		unique case (dataSel)
			selDin:    captureMux = sources.dinData;
			selRegB:   captureMux = sources.regBData;
			selCc:     captureMux = sources.ccData;
			selPcNext: captureMux = sources.pcNext;
			default:   captureMux = sources.dinData;
		endcase
	end

	always_ff @(posedge clk) begin
		if (ldDataEn) capture <= captureMux;
	end

	// Host read mux, zero when not reading
	always_comb begin
		dout = '0;
		if (!rdN) begin
			case (addr)
				regMode:   dout = {5'b0, ctrl.cpuResetReq, ctrl.debugMode, ctrl.debugStop};
				regOp:     dout = {4'b0, ctrl.op};
				regDataL:  dout = capture[7:0];
				regDataH:  dout = capture[15:8];
				regAddrL:  dout = debugAddr[7:0];
				regAddrH:  dout = debugAddr[15:8];
				regStatus: dout = {7'b0, busy};
				default:   dout = '0;	// Spare
			endcase
		end
	end

endmodule

//--- verilog/debugAddrCounter.sv
module debugAddrCounter import debugPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  logic       wrValid,
	input  hostWrite_t hostWr,
	input  logic       addrIncEn,	// CPU advance, one word
	output word_t      debugAddr
);

	// Word address, byte bit 0 is implied zero
	logic [14:0] wordAddr;
	logic        loadL;
	logic        loadH;

	assign loadL = wrValid & (hostWr.regSel == regAddrL);
	assign loadH = wrValid & (hostWr.regSel == regAddrH);

	// **********************************************************
	// Counter
	// **********************************************************
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wordAddr <= '0;
		end else if (loadL) begin
			wordAddr[6:0] <= hostWr.data[7:1];	// Drop byte bit 0
		end else if (loadH) begin
			wordAddr[14:7] <= hostWr.data;
		end else if (addrIncEn) begin
			// Carry crosses the byte boundary
			wordAddr <= wordAddr + 15'd1;
		end
	end

	assign debugAddr = {wordAddr, 1'b0};

endmodule

//--- verilog/debugRequestFsm.sv
module debugRequestFsm import debugPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  logic       wrValid,
	input  hostWrite_t hostWr,
	input  logic       autoInc,	// Op bit 0
	input  logic       debugAck,	// From CPU
	output logic       debugReq,	// To CPU
	output logic       busy		// Status bit 0
);

	reqState_e state;
	reqState_e nextState;
	logic      modeReq;
	logic      incReq;
	logic      reqEvent;

	// **********************************************************
	// Request decode
	// **********************************************************
	assign modeReq  = (hostWr.regSel == regMode) & hostWr.data[modeReqBit];
	assign incReq   = (hostWr.regSel == regDataH) & autoInc;	// Auto-increment write
	assign reqEvent = wrValid & (modeReq | incReq);

	// **********************************************************
	// Four-phase handshake
	// **********************************************************
	always_comb begin
		nextState = state;
		unique case (state)
			reqIdle: begin
				if (reqEvent) nextState = reqRaised;	// Events ignored elsewhere
			end
			reqRaised: begin
				if (debugAck) nextState = reqRelease;	// CPU took it
			end
			reqRelease: begin
				if (!debugAck) nextState = reqIdle;	// CPU done
			end
			default: nextState = reqIdle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state    <= reqIdle;
			debugReq <= 1'b0;
		end else begin
			state    <= nextState;
			debugReq <= (nextState == reqRaised);	// Registered from state
		end
	end

	// Busy until the CPU has dropped its ack
	assign busy = (state != reqIdle) | debugAck;

endmodule

//--- verilog/hostBusSync.sv
module hostBusSync import debugPkg::*; (
	input  logic       clk,
	input  logic       arstN,
	input  logic       wrN,		// Host write strobe, asynchronous
	input  regAddr_e   addr,	// Held by host past the strobe
	input  byte_t      din,
	output logic       wrValid,	// One cycle per completed write
	output hostWrite_t hostWr
);

	// **********************************************************
	// Strobe synchronizer
	// **********************************************************
	logic [syncStages-1:0] wrSync;
	logic                  wrPrev;	// Last synchronized strobe level
	logic                  wrLevel;

	assign wrLevel = wrSync[syncStages-1];

	// Idle strobe is high, so the chain resets to ones
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrSync <= '1;
			wrPrev <= 1'b1;
		end else begin
			wrSync <= {wrSync[syncStages-2:0], wrN};
			wrPrev <= wrLevel;
		end
	end

	// Release of the strobe ends the write
	assign wrValid = wrLevel & ~wrPrev;

	// **********************************************************
	// Event capture
	// **********************************************************

	// Sample address and data while the strobe still reads low.
	// The host holds both stable, so the last sample taken before
	// the edge is the one presented with wrValid.
	always_ff @(posedge clk) begin
		if (!wrLevel) begin
			hostWr.regSel <= addr;
			hostWr.data   <= din;
		end
	end

endmodule

//--- verilog/debugPkg.sv
package debugPkg;

	// **********************************************************
	// Widths
	// **********************************************************
	typedef logic [7:0]  byte_t;	// Host bus byte
	typedef logic [15:0] word_t;	// CPU word and address
	typedef logic [3:0]  op_t;	// Debug op, bit 0 is auto-increment

	localparam int syncStages = 2;	// Write strobe synchronizer depth
	localparam int modeReqBit = 3;	// Request flag in a mode write

	// Host register map
	typedef enum logic [2:0] {
		regMode   = 3'd0,
		regOp     = 3'd1,
		regDataL  = 3'd2,	// Write data low / capture low
		regDataH  = 3'd3,	// Write data high / capture high
		regAddrL  = 3'd4,
		regAddrH  = 3'd5,
		regStatus = 3'd6,
		regSpare  = 3'd7	// Reads zero
	} regAddr_e;

	// Capture source select, driven by the CPU
	typedef enum logic [1:0] {
		selDin    = 2'd0,
		selRegB   = 2'd1,
		selCc     = 2'd2,
		selPcNext = 2'd3
	} dataSel_e;

	// Four-phase request states
	typedef enum logic [1:0] {
		reqIdle    = 2'd0,
		reqRaised  = 2'd1,
		reqRelease = 2'd2
	} reqState_e;

	// One synchronized host write
	typedef struct packed {
		regAddr_e regSel;
		byte_t    data;
	} hostWrite_t;

	// Control bits to the CPU, mode bits 2..0 then op
	typedef struct packed {
		logic cpuResetReq;
		logic debugMode;
		logic debugStop;
		op_t  op;
	} debugCtrl_t;

	typedef struct packed {
		word_t dinData;		// Data bus input
		word_t regBData;	// Register file port B
		word_t ccData;		// Condition codes
		word_t pcNext;		// Next program counter
	} captureSrc_t;

endpackage
